//--- all.f
common/calib_pkg.sv
common/calib_cfg_if.sv
design/adc_capture.sv
calib/linear_calib.sv
calib/calib_regs.sv
design/dac_format.sv
design/analog_top.sv
testbench/analog_props.sv
testbench/analog_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator from all.f and run, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module analog_tb -o sim_analog &&
./obj_dir/sim_analog || exit 1

//--- testbench/analog_tb.sv
// Testbench top for the analog front end, random streams and register traffic for bound checks
`timescale 1ns/100ps

module analog_tb;

  localparam int unsigned CHN_NUM     = 2;
  localparam time         DRV_DLY     = 10ns;
  localparam int          ACK_TIMEOUT = 16;
  localparam logic [15:0] LFSR_SEED   = 16'd61;
  localparam logic [15:0] LFSR_TAPS   = 16'hb400;

  logic                                  adc_clk;
  logic                                  top_rst;
  calib_pkg::adc_raw_t                   adc_dat_i [CHN_NUM];
  calib_pkg::sample_t                    gen_dat_i [CHN_NUM];
  calib_pkg::sample_t                    acq_dat_o [CHN_NUM];
  logic [CHN_NUM-1:0]                    acq_vld_o;
  logic [$bits(calib_pkg::sample_t)-1:0] dac_dat_o [CHN_NUM];
  logic                                  wb_cyc_i;
  logic                                  wb_stb_i;
  logic                                  wb_we_i;
  calib_pkg::wb_adr_t                    wb_adr_i;
  calib_pkg::wb_dat_t                    wb_dat_i;
  calib_pkg::wb_dat_t                    wb_dat_o;
  logic                                  wb_ack_o;

  // Random source state and stream enable
  logic [15:0] lfsr_q;
  logic        stim_en;

  analog_top #(
    .CHN_NUM (CHN_NUM)
  ) i_dut (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .gen_dat_i (gen_dat_i),
    .acq_dat_o (acq_dat_o),
    .acq_vld_o (acq_vld_o),
    .dac_dat_o (dac_dat_o),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o)
  );

  bind analog_top analog_props #(
    .CHN_NUM (CHN_NUM)
  ) i_props (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .gen_dat_i (gen_dat_i),
    .acq_dat_o (acq_dat_o),
    .acq_vld_o (acq_vld_o),
    .dac_dat_o (dac_dat_o),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_ack_o  (wb_ack_o)
  );

  // 100 ns period
  initial begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[14:0], lfsr_q[0]};
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge adc_clk);
    #(DRV_DLY);
  endtask

  function automatic calib_pkg::wb_adr_t chn_adr(input int c, input int unsigned ofs);
    return calib_pkg::wb_adr_t'(calib_pkg::REG_CHN_BASE + c * calib_pkg::REG_CHN_STRIDE + ofs);
  endfunction

  // One classic cycle, held until ack
  task automatic bus_cycle(input logic we, input calib_pkg::wb_adr_t adr,
                           input calib_pkg::wb_dat_t dat, output calib_pkg::wb_dat_t rdat);
    int n;
    n        = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(posedge adc_clk);
      #(DRV_DLY);
      n++;
    end while (!wb_ack_o && n < ACK_TIMEOUT);
    if (!wb_ack_o) abort_run($sformatf("no Wishbone ack for address 0x%h", adr));
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic reg_write(input calib_pkg::wb_adr_t adr, input calib_pkg::wb_dat_t dat);
    calib_pkg::wb_dat_t dummy;
    bus_cycle(1'b1, adr, dat, dummy);
  endtask

  task automatic reg_check(input calib_pkg::wb_adr_t adr, input calib_pkg::wb_dat_t exp);
    calib_pkg::wb_dat_t got;
    bus_cycle(1'b0, adr, 16'h0000, got);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] wb_dat_o at 0x%h: got 0x%h, expected 0x%h", adr, got, exp));
    end
  endtask

  // Free running random streams on both paths
  always begin : stim
    logic [15:0] r;
    @(posedge adc_clk);
    #(DRV_DLY);
    if (stim_en) begin
      for (int c = 0; c < CHN_NUM; c++) begin
        rand_bits(14, r);
        adc_dat_i[c] = r[13:0];
        rand_bits(14, r);
        gen_dat_i[c] = r[13:0];
      end
    end
  end

  // Assertion failures end the run
  always @(posedge adc_clk) begin
    if (i_dut.i_props.fail_cnt != 0) abort_run("assertion failure reported by analog_props");
  end

  initial begin
    top_rst  = 1'b1;
    stim_en  = 1'b0;
    lfsr_q   = LFSR_SEED;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    for (int c = 0; c < CHN_NUM; c++) begin
      adc_dat_i[c] = '0;
      gen_dat_i[c] = '0;
    end
    wait_cycles(16);
    top_rst = 1'b0;
    stim_en = 1'b1;

    // Reset values
    reg_check(calib_pkg::REG_LOOP, 16'h0000);
    for (int c = 0; c < CHN_NUM; c++) begin
      reg_check(chn_adr(c, calib_pkg::REG_ADC_GAIN), calib_pkg::GAIN_UNITY);
      reg_check(chn_adr(c, calib_pkg::REG_ADC_OFS), 16'h0000);
      reg_check(chn_adr(c, calib_pkg::REG_DAC_GAIN), calib_pkg::GAIN_UNITY);
      reg_check(chn_adr(c, calib_pkg::REG_DAC_OFS), 16'h0000);
    end

    // Unmapped words read zero and drop writes
    reg_check(chn_adr(CHN_NUM, 0), 16'h0000);
    reg_write(4'hf, 16'h1234);
    reg_check(4'hf, 16'h0000);

    // Unity path
    wait_cycles(40);

    // Gain near two on ch0 clamps both ways, ch1 gets -0.75
    reg_write(chn_adr(0, calib_pkg::REG_ADC_GAIN), 16'h7fff);
    reg_write(chn_adr(0, calib_pkg::REG_ADC_OFS), 16'd3000);
    reg_write(chn_adr(1, calib_pkg::REG_ADC_GAIN), 16'hd000);
    reg_write(chn_adr(1, calib_pkg::REG_ADC_OFS), 16'hf63c);
    reg_check(chn_adr(0, calib_pkg::REG_ADC_GAIN), 16'h7fff);
    reg_check(chn_adr(1, calib_pkg::REG_ADC_OFS), 16'hf63c);
    wait_cycles(60);

    // DAC side settings
    reg_write(chn_adr(0, calib_pkg::REG_DAC_GAIN), 16'h2000);
    reg_write(chn_adr(0, calib_pkg::REG_DAC_OFS), 16'd100);
    reg_write(chn_adr(1, calib_pkg::REG_DAC_GAIN), 16'h7fff);
    reg_write(chn_adr(1, calib_pkg::REG_DAC_OFS), 16'hf060);
    reg_check(chn_adr(1, calib_pkg::REG_DAC_OFS), 16'hf060);
    wait_cycles(40);

    // Loopback one channel at a time
    reg_write(calib_pkg::REG_LOOP, 16'h0001);
    reg_check(calib_pkg::REG_LOOP, 16'h0001);
    wait_cycles(40);
    reg_write(calib_pkg::REG_LOOP, 16'h0002);
    reg_check(calib_pkg::REG_LOOP, 16'h0002);
    wait_cycles(40);
    reg_write(calib_pkg::REG_LOOP, 16'h0000);
    wait_cycles(20);

    if (i_dut.i_props.fail_cnt != 0) begin
      abort_run("assertion failures seen during the run");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule : analog_tb

//--- testbench/analog_props.sv
// Bound checker for analog_top, tracks register writes and asserts datapath and bus timing
`timescale 1ns/100ps

module analog_props #(
  parameter int unsigned CHN_NUM = 2
) (
  input logic                                  adc_clk,
  input logic                                  top_rst,
  input calib_pkg::adc_raw_t                   adc_dat_i [CHN_NUM],
  input calib_pkg::sample_t                    gen_dat_i [CHN_NUM],
  input calib_pkg::sample_t                    acq_dat_o [CHN_NUM],
  input logic [CHN_NUM-1:0]                    acq_vld_o,
  input logic [$bits(calib_pkg::sample_t)-1:0] dac_dat_o [CHN_NUM],
  input logic                                  wb_cyc_i,
  input logic                                  wb_stb_i,
  input logic                                  wb_we_i,
  input calib_pkg::wb_adr_t                    wb_adr_i,
  input calib_pkg::wb_dat_t                    wb_dat_i,
  input logic                                  wb_ack_o
);

  // Shadow copy of the settings, rebuilt from bus writes
  int                 adc_gain [CHN_NUM];
  int                 adc_ofs  [CHN_NUM];
  int                 dac_gain [CHN_NUM];
  int                 dac_ofs  [CHN_NUM];
  logic [CHN_NUM-1:0] loop;
  // Edges since reset or since the last write, saturating
  int unsigned        quiet;
  int unsigned        up_cnt;
  // Failed assertion count, watched by the testbench
  int unsigned        fail_cnt = 0;

  // Negative slope ADC code to signed value
  function automatic int adc_conv(input logic [13:0] raw);
    logic [13:0] s;
    s = raw ^ 14'h1fff;
    return int'($signed(s));
  endfunction

  // Gain with 14 fraction bits, then offset, then clamp to 14 bits signed
  function automatic int calib(input int x, input int g, input int o);
    int y;
    y = ((x * g) >>> calib_pkg::GAIN_FRAC_BITS) + o;
    if (y > 8191) begin
      y = 8191;
    end else if (y < -8192) begin
      y = -8192;
    end
    return y;
  endfunction

  // Signed value to DAC code, sign bit kept
  function automatic logic [13:0] dac_code(input int s);
    return 14'(s) ^ 14'h1fff;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Shadow registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      loop   <= '0;
      quiet  <= 0;
      up_cnt <= 0;
      for (int c = 0; c < CHN_NUM; c++) begin
        adc_gain[c] <= int'(calib_pkg::GAIN_UNITY);
        adc_ofs[c]  <= 0;
        dac_gain[c] <= int'(calib_pkg::GAIN_UNITY);
        dac_ofs[c]  <= 0;
      end
    end else begin
      if (up_cnt < 15) up_cnt <= up_cnt + 1;
      if (quiet < 15) quiet <= quiet + 1;
      // Write lands on the ack edge
      if (wb_cyc_i && wb_stb_i && wb_we_i && !wb_ack_o) begin
        quiet <= 0;
        if (wb_adr_i == calib_pkg::REG_LOOP) loop <= wb_dat_i[CHN_NUM-1:0];
        for (int c = 0; c < CHN_NUM; c++) begin
          if (int'(wb_adr_i) == calib_pkg::REG_CHN_BASE + c * calib_pkg::REG_CHN_STRIDE) begin
            adc_gain[c] <= int'($signed(wb_dat_i));
          end
          if (int'(wb_adr_i) == calib_pkg::REG_CHN_BASE + c * calib_pkg::REG_CHN_STRIDE + 1) begin
            adc_ofs[c] <= int'($signed(wb_dat_i[13:0]));
          end
          if (int'(wb_adr_i) == calib_pkg::REG_CHN_BASE + c * calib_pkg::REG_CHN_STRIDE + 2) begin
            dac_gain[c] <= int'($signed(wb_dat_i));
          end
          if (int'(wb_adr_i) == calib_pkg::REG_CHN_BASE + c * calib_pkg::REG_CHN_STRIDE + 3) begin
            dac_ofs[c] <= int'($signed(wb_dat_i[13:0]));
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone handshake
  ////////////////////////////////////////////////////////////////////////////

  a_ack_rst: assert property (@(posedge adc_clk) top_rst |-> !wb_ack_o)
    else begin fail_cnt++; $error("ack high during reset"); end
  a_ack_rise: assert property (@(posedge adc_clk) disable iff (top_rst)
    wb_cyc_i && wb_stb_i && !wb_ack_o |=> wb_ack_o)
    else begin fail_cnt++; $error("ack missing one cycle after request"); end
  a_ack_pulse: assert property (@(posedge adc_clk) disable iff (top_rst)
    wb_ack_o |=> !wb_ack_o)
    else begin fail_cnt++; $error("ack longer than one cycle"); end
  a_ack_idle: assert property (@(posedge adc_clk) disable iff (top_rst)
    !(wb_cyc_i && wb_stb_i) |=> !wb_ack_o)
    else begin fail_cnt++; $error("ack without request"); end

  ////////////////////////////////////////////////////////////////////////////
  // Per channel datapath
  ////////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < CHN_NUM; c++) begin : g_chk
    // Valid rises three edges after reset release
    a_vld: assert property (@(posedge adc_clk) acq_vld_o[c] == (up_cnt >= 3))
      else begin fail_cnt++; $error("acq_vld_o wrong on channel %0d", c); end
    // Mid scale code while in reset
    a_dac_rst: assert property (@(posedge adc_clk) top_rst |-> dac_dat_o[c] == 14'h1fff)
      else begin fail_cnt++; $error("DAC code not zero in reset on channel %0d", c); end
    // ADC path, 3 cycles
    a_adc: assert property (@(posedge adc_clk) disable iff (top_rst)
      quiet >= 6 && !loop[c] |-> int'(acq_dat_o[c]) ==
        calib(adc_conv($past(adc_dat_i[c], 3)), adc_gain[c], adc_ofs[c]))
      else begin fail_cnt++; $error("ADC path mismatch on channel %0d", c); end
    // DAC path, 3 cycles
    a_dac: assert property (@(posedge adc_clk) disable iff (top_rst)
      quiet >= 6 |-> dac_dat_o[c] ==
        dac_code(calib(int'($past(gen_dat_i[c], 3)), dac_gain[c], dac_ofs[c])))
      else begin fail_cnt++; $error("DAC path mismatch on channel %0d", c); end
    // Loopback, both calibrations, 5 cycles
    a_loop: assert property (@(posedge adc_clk) disable iff (top_rst)
      quiet >= 6 && loop[c] |-> int'(acq_dat_o[c]) ==
        calib(calib(int'($past(gen_dat_i[c], 5)), dac_gain[c], dac_ofs[c]),
              adc_gain[c], adc_ofs[c]))
      else begin fail_cnt++; $error("loopback mismatch on channel %0d", c); end
  end : g_chk

endmodule : analog_props

//--- design/analog_top.sv
// Analog front end top, wires capture, calibration and DAC formatting per channel
`timescale 1ns/100ps

module analog_top #(
  // Number of analog channels, 1 to 3
  parameter int unsigned CHN_NUM = 2
) (
  input  logic                                  adc_clk,
  input  logic                                  top_rst,
  // ADC words
  input  calib_pkg::adc_raw_t                   adc_dat_i [CHN_NUM],
  // Generator samples
  input  calib_pkg::sample_t                    gen_dat_i [CHN_NUM],
  // Acquisition stream
  output calib_pkg::sample_t                    acq_dat_o [CHN_NUM],
  output logic [CHN_NUM-1:0]                    acq_vld_o,
  // DAC codes
  output logic [$bits(calib_pkg::sample_t)-1:0] dac_dat_o [CHN_NUM],
  // Wishbone register port
  input  logic                                  wb_cyc_i,
  input  logic                                  wb_stb_i,
  input  logic                                  wb_we_i,
  input  calib_pkg::wb_adr_t                    wb_adr_i,
  input  calib_pkg::wb_dat_t                    wb_dat_i,
  output calib_pkg::wb_dat_t                    wb_dat_o,
  output logic                                  wb_ack_o
);

  //////////////////////////////////////////////////////////////////////////
  // Settings
  //////////////////////////////////////////////////////////////////////////

  calib_cfg_if #(.CHN_NUM (CHN_NUM)) cfg ();

  calib_regs #(
    .CHN_NUM (CHN_NUM)
  ) i_regs (
    .clk_i    (adc_clk),
    .rst_i    (top_rst),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .cfg      (cfg.regs)
  );

  //////////////////////////////////////////////////////////////////////////
  // Per channel datapath
  //////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CHN_NUM; i++) begin : g_chn

    // Captured ADC stream
    calib_pkg::sample_t cap_dat;
    logic               cap_vld;
    // Calibrated DAC-side sample, also the loopback source
    calib_pkg::sample_t gen_cal;

    adc_capture i_capture (
      .clk_i      (adc_clk),
      .rst_i      (top_rst),
      .raw_i      (adc_dat_i[i]),
      .loop_i     (cfg.loop[i]),
      .loop_dat_i (gen_cal),
      .dat_o      (cap_dat),
      .vld_o      (cap_vld)
    );

    // ADC side calibration
    linear_calib i_adc_calib (
      .clk_i  (adc_clk),
      .rst_i  (top_rst),
      .dat_i  (cap_dat),
      .vld_i  (cap_vld),
      .gain_i (cfg.adc_gain[i]),
      .ofs_i  (cfg.adc_ofs[i]),
      .dat_o  (acq_dat_o[i]),
      .vld_o  (acq_vld_o[i])
    );

    // DAC side calibration, generator runs every cycle
    linear_calib i_dac_calib (
      .clk_i  (adc_clk),
      .rst_i  (top_rst),
      .dat_i  (gen_dat_i[i]),
      .vld_i  (1'b1),
      .gain_i (cfg.dac_gain[i]),
      .ofs_i  (cfg.dac_ofs[i]),
      .dat_o  (gen_cal),
      .vld_o  ()
    );

    dac_format i_dac_format (
      .clk_i (adc_clk),
      .rst_i (top_rst),
      .dat_i (gen_cal),
      .dac_o (dac_dat_o[i])
    );

  end : g_chn

endmodule : analog_top

//--- design/dac_format.sv
// DAC output register, signed sample to offset-binary negative-slope code, one channel
`timescale 1ns/100ps

module dac_format (
  input  logic                                      clk_i,
  input  logic                                      rst_i,
  // Calibrated generator sample
  input  calib_pkg::sample_t                        dat_i,
  // Converter code
  output logic [$bits(calib_pkg::sample_t)-1:0]     dac_o
);

  // Code width follows the sample width
  localparam int DW = $bits(calib_pkg::sample_t);

  // Zero sample maps to MSB low, all other bits high
  localparam logic [DW-1:0] CODE_ZERO = {1'b0, {(DW-1){1'b1}}};

  // Converted code before the output register
  logic [DW-1:0] code;

  // Keep the sign bit, flip the magnitude bits
  assign code = {dat_i[DW-1], ~dat_i[DW-2:0]};

  // Output register, idles at mid scale
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      dac_o <= CODE_ZERO;
    end else begin
      dac_o <= code;
    end
  end

endmodule : dac_format

//--- calib/calib_regs.sv
// Wishbone classic register block with per-channel gains, offsets and loopback bits
`timescale 1ns/100ps

module calib_regs #(
  // Number of analog channels
  parameter int unsigned CHN_NUM = 2
) (
  input  logic               clk_i,
  input  logic               rst_i,
  // Wishbone classic slave
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  calib_pkg::wb_adr_t wb_adr_i,
  input  calib_pkg::wb_dat_t wb_dat_i,
  output calib_pkg::wb_dat_t wb_dat_o,
  output logic               wb_ack_o,
  // Settings toward the datapath
  calib_cfg_if.regs          cfg
);

  // New bus cycle, seen once per transfer
  logic               req;
  logic               wr_en;

  // Address decode
  logic               hit_loop;
  logic               hit_chn;
  calib_pkg::wb_adr_t rel_adr;
  calib_pkg::wb_adr_t chn_sel;
  calib_pkg::wb_adr_t reg_sel;

  // Read mux result
  calib_pkg::wb_dat_t rd_dat;

  ////////////////////////////////////////////////////////////////////////////
  // Bus handshake
  ////////////////////////////////////////////////////////////////////////////

  // Ack low gates the request, so ack lasts one cycle
  assign req   = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_en = req & wb_we_i;

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rel_adr  = wb_adr_i - calib_pkg::REG_CHN_BASE;
    hit_loop = (wb_adr_i == calib_pkg::REG_LOOP);
    // Channel window is CHN_NUM blocks past the base
    hit_chn  = (wb_adr_i >= calib_pkg::REG_CHN_BASE) &&
               (rel_adr < CHN_NUM * calib_pkg::REG_CHN_STRIDE);
    chn_sel  = calib_pkg::wb_adr_t'(rel_adr / calib_pkg::REG_CHN_STRIDE);
    reg_sel  = calib_pkg::wb_adr_t'(rel_adr % calib_pkg::REG_CHN_STRIDE);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Settings storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      // Unity gain, no offset, no loopback
      cfg.loop <= '0;
      for (int i = 0; i < CHN_NUM; i++) begin
        cfg.adc_gain[i] <= calib_pkg::GAIN_UNITY;
        cfg.adc_ofs[i]  <= '0;
        cfg.dac_gain[i] <= calib_pkg::GAIN_UNITY;
        cfg.dac_ofs[i]  <= '0;
      end
    end else if (wr_en) begin
      if (hit_loop) begin
        cfg.loop <= wb_dat_i[CHN_NUM-1:0];
      end
      for (int i = 0; i < CHN_NUM; i++) begin
        if (hit_chn && (chn_sel == i)) begin
          // Offsets keep the low sample bits only
          case (reg_sel)
            calib_pkg::REG_ADC_GAIN: cfg.adc_gain[i] <= calib_pkg::gain_t'(wb_dat_i);
            calib_pkg::REG_ADC_OFS:  cfg.adc_ofs[i]  <= calib_pkg::sample_t'(wb_dat_i);
            calib_pkg::REG_DAC_GAIN: cfg.dac_gain[i] <= calib_pkg::gain_t'(wb_dat_i);
            calib_pkg::REG_DAC_OFS:  cfg.dac_ofs[i]  <= calib_pkg::sample_t'(wb_dat_i);
            default: ;
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  // Unmapped words read zero, narrow words are sign extended
  always_comb begin
    rd_dat = '0;
    if (hit_loop) begin
      rd_dat[CHN_NUM-1:0] = cfg.loop;
    end else if (hit_chn) begin
      for (int i = 0; i < CHN_NUM; i++) begin
        if (chn_sel == i) begin
          case (reg_sel)
            calib_pkg::REG_ADC_GAIN: rd_dat = calib_pkg::wb_dat_t'(cfg.adc_gain[i]);
            calib_pkg::REG_ADC_OFS:  rd_dat = calib_pkg::wb_dat_t'(cfg.adc_ofs[i]);
            calib_pkg::REG_DAC_GAIN: rd_dat = calib_pkg::wb_dat_t'(cfg.dac_gain[i]);
            calib_pkg::REG_DAC_OFS:  rd_dat = calib_pkg::wb_dat_t'(cfg.dac_ofs[i]);
            default: rd_dat = '0;
          endcase
        end
      end
    end
  end

  // Captured with the ack, held while ack is high
  always_ff @(posedge clk_i) begin
    if (req) begin
      wb_dat_o <= rd_dat;
    end
  end

endmodule : calib_regs

//--- calib/linear_calib.sv
// Gain, offset and saturation stage, two registers deep, shared by ADC and DAC paths
`timescale 1ns/100ps

module linear_calib (
  input  logic               clk_i,
  input  logic               rst_i,
  // Input stream
  input  calib_pkg::sample_t dat_i,
  input  logic               vld_i,
  // Settings
  input  calib_pkg::gain_t   gain_i,
  input  calib_pkg::sample_t ofs_i,
  // Calibrated stream
  output calib_pkg::sample_t dat_o,
  output logic               vld_o
);

  // Sample width and full product width
  localparam int DW     = $bits(calib_pkg::sample_t);
  localparam int PROD_W = DW + $bits(calib_pkg::gain_t);

  // Output limits of a signed sample
  localparam int SAT_MAX = (1 <<< (DW - 1)) - 1;
  localparam int SAT_MIN = -(1 <<< (DW - 1));

  // Stage 1 registers
  logic signed [PROD_W-1:0] prod_q;
  calib_pkg::sample_t       ofs_q;
  logic                     vld_q;

  // Scaled product plus offset, one guard bit
  logic signed [PROD_W:0]   sum;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1, multiply
  ////////////////////////////////////////////////////////////////////////////

  // Offset is sampled with the product so both belong to one sample
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      prod_q <= '0;
      ofs_q  <= '0;
      vld_q  <= 1'b0;
    end else begin
      prod_q <= dat_i * gain_i;
      ofs_q  <= ofs_i;
      vld_q  <= vld_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2, add and clamp
  ////////////////////////////////////////////////////////////////////////////

  // Arithmetic shift drops the gain fraction
  assign sum = (prod_q >>> calib_pkg::GAIN_FRAC_BITS) + ofs_q;

  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      dat_o <= '0;
      vld_o <= 1'b0;
    end else begin
      // Clamp to the nearest limit
      if (sum > SAT_MAX) begin
        dat_o <= calib_pkg::sample_t'(SAT_MAX);
      end else if (sum < SAT_MIN) begin
        dat_o <= calib_pkg::sample_t'(SAT_MIN);
      end else begin
        dat_o <= calib_pkg::sample_t'(sum);
      end
      vld_o <= vld_q;
    end
  end

endmodule : linear_calib

//--- design/adc_capture.sv
// ADC input register, offset-binary to signed conversion and loopback select, one channel
`timescale 1ns/100ps

module adc_capture (
  input  logic               clk_i,
  input  logic               rst_i,
  // Raw converter word
  input  calib_pkg::adc_raw_t raw_i,
  // Loopback select and DAC-side sample
  input  logic               loop_i,
  input  calib_pkg::sample_t loop_dat_i,
  // Captured sample stream
  output calib_pkg::sample_t dat_o,
  output logic               vld_o
);

  // Converted ADC sample
  calib_pkg::sample_t adc_smp;
  // Sample picked for the register
  calib_pkg::sample_t sel_smp;

  // Negative slope, so keep MSB and flip the rest
  assign adc_smp = {raw_i[$bits(raw_i)-1], ~raw_i[$bits(raw_i)-2:0]};

  // Loopback replaces the converter sample
  assign sel_smp = loop_i ? loop_dat_i : adc_smp;

  // Input register, single stage
  always_ff @(posedge clk_i) begin
    dat_o <= sel_smp;
  end

  // Stream is free running once out of reset
  always_ff @(posedge clk_i, posedge rst_i) begin
    if (rst_i) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= 1'b1;
    end
  end

endmodule : adc_capture

//--- common/calib_cfg_if.sv
// Calibration and loopback settings, driven by the register block, read per channel
`timescale 1ns/100ps

interface calib_cfg_if #(
  // Number of analog channels
  parameter int unsigned CHN_NUM = 2
) ();

  // ADC side gain and offset
  calib_pkg::gain_t   adc_gain [CHN_NUM];
  calib_pkg::sample_t adc_ofs  [CHN_NUM];

  // DAC side gain and offset
  calib_pkg::gain_t   dac_gain [CHN_NUM];
  calib_pkg::sample_t dac_ofs  [CHN_NUM];

  // Digital loopback select per channel
  logic [CHN_NUM-1:0] loop;

  // Register block owns all settings
  modport regs (
    output adc_gain,
    output adc_ofs,
    output dac_gain,
    output dac_ofs,
    output loop
  );

  // Datapath side only reads them
  modport stage (
    input adc_gain,
    input adc_ofs,
    input dac_gain,
    input dac_ofs,
    input loop
  );

endinterface : calib_cfg_if

//--- common/calib_pkg.sv
// Shared types and register map for the analog front end, used by scoped name
package calib_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Datapath types
  //////////////////////////////////////////////////////////////////////////

  // Signed sample on both the acquisition and generation side
  typedef logic signed [14-1:0] sample_t;

  // Raw converter word, bits 15 down to 2 of the ADC bus
  typedef logic [14-1:0] adc_raw_t;

  // Gain in signed fixed point, 2 integer bits
  typedef logic signed [16-1:0] gain_t;

  // Fraction bits of gain_t
  localparam int unsigned GAIN_FRAC_BITS = 14;

  // Gain of exactly one
  localparam gain_t GAIN_UNITY = 16'sd16384;

  //////////////////////////////////////////////////////////////////////////
  // Register bus types
  //////////////////////////////////////////////////////////////////////////

  // Wishbone word address
  typedef logic [4-1:0] wb_adr_t;

  // Wishbone data word
  typedef logic [16-1:0] wb_dat_t;

  //////////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////////

  // Loopback enables, one bit per channel
  localparam wb_adr_t REG_LOOP = 4'd0;

  // Per-channel blocks follow the loopback word
  localparam wb_adr_t     REG_CHN_BASE   = 4'd1;
  localparam int unsigned REG_CHN_STRIDE = 4;

  // Word offsets inside one channel block
  localparam int unsigned REG_ADC_GAIN = 0;
  localparam int unsigned REG_ADC_OFS  = 1;
  localparam int unsigned REG_DAC_GAIN = 2;
  localparam int unsigned REG_DAC_OFS  = 3;

endpackage : calib_pkg
